// File: soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// memory and address map
////////////////////////////////////////////////////////////////////////////

// byte address width of each ram, 14 gives 4096 words
`define SOC_MEM_ADDR_W 14
// boot done marker, hit by the last boot instruction
`define SOC_BOOT_DONE_ADDR 32'hffff_fffc

////////////////////////////////////////////////////////////////////////////
// reset and uart
////////////////////////////////////////////////////////////////////////////

// cycles of internal reset after external release
`define SOC_POR_CYCLES 16
// soft reset pulse length for the processor
`define SOC_CORE_RST_CYCLES 4
`define UART_DIV_W 32
`define UART_DIV_RESET 8

`endif

// File: bus_pkg.sv
package bus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // native bus vectors
   ////////////////////////////////////////////////////////////////////////////

   // byte address
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   // byte write enables, zero means read
   typedef logic [3:0] strb_t;
   // slave index, addr bits 31:30
   typedef logic [1:0] slave_sel_t;

   ////////////////////////////////////////////////////////////////////////////
   // request and response bundles
   ////////////////////////////////////////////////////////////////////////////

   // master to slave, held until ready
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

   // slave to master, rdata only meaningful with ready
   typedef struct packed {
      logic  ready;
      data_t rdata;
   } bus_rsp_t;

endpackage

// File: uart_pkg.sv
`include "soc_config.svh"

package uart_pkg;

   // one serial character
   typedef logic [7:0] uart_byte_t;
   // clocks per bit
   typedef logic [`UART_DIV_W-1:0] baud_div_t;

   // shared by the tx and rx machines
   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } uart_state_t;

endpackage

// File: reset_sequencer.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module reset_sequencer import bus_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  bus_req_t req,
   input  logic     rsp_ready,
   output logic     resetn_int,
   output logic     core_resetn,
   output logic     mem_sel
);

   localparam int POR_W  = $clog2(`SOC_POR_CYCLES + 1);
   localparam int SOFT_W = $clog2(`SOC_CORE_RST_CYCLES + 1);

   logic [POR_W-1:0]  por_cnt;
   logic [SOFT_W-1:0] soft_cnt;
   logic              boot_done;

   // power on count, stops once internal reset is released
   always_ff @(posedge clk) begin
      if (!reset) begin
         por_cnt    <= '0;
         resetn_int <= 1'b0;
      end else if (!resetn_int) begin
         por_cnt <= por_cnt + 1'b1;
         // last count edge releases
         if (por_cnt == POR_W'(`SOC_POR_CYCLES - 1)) begin
            resetn_int <= 1'b1;
         end
      end
   end

   // accepted transfer to the marker address
   assign boot_done = req.valid && rsp_ready && (req.addr == `SOC_BOOT_DONE_ADDR);

   // soft reset timer and sticky remap flag
   always_ff @(posedge clk) begin
      if (!reset || !resetn_int) begin
         soft_cnt <= '0;
         mem_sel  <= 1'b0;
      end else if (boot_done) begin
         soft_cnt <= SOFT_W'(`SOC_CORE_RST_CYCLES);
         mem_sel  <= 1'b1;
      end else if (soft_cnt != '0) begin
         soft_cnt <= soft_cnt - 1'b1;
      end
   end

   // processor held while either reset source is active
   assign core_resetn = resetn_int && (soft_cnt == '0);

   // release lands exactly the power on count after the external release
   a_por_length: assert property (@(posedge clk) $rose(resetn_int) |->
      $past(reset, `SOC_POR_CYCLES) && !$past(reset, `SOC_POR_CYCLES + 1));

endmodule

// File: native_interconnect.sv
`timescale 1ns/1ps

module native_interconnect import bus_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       mem_sel,
   input  bus_req_t   m_req,
   output bus_rsp_t   m_rsp,
   output bus_req_t   s_req [0:3],
   input  bus_rsp_t   s_rsp [0:3],
   output slave_sel_t s_sel
);

   slave_sel_t dec_sel;
   slave_sel_t held_sel;
   slave_sel_t sel;
   logic       busy;

   ////////////////////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////////////////////

   // top two address bits pick the slot
   always_comb begin
      dec_sel = m_req.addr[31:30];
      // after boot, slot 0 goes to main memory
      if (mem_sel && (dec_sel == 2'd0)) begin
         dec_sel = 2'd3;
      end
   end

   // hold the choice while a slave stalls
   always_ff @(posedge clk) begin
      if (!reset) begin
         busy <= 1'b0;
      end else if (m_rsp.ready) begin
         busy <= 1'b0;
      end else if (m_req.valid && !busy) begin
         busy <= 1'b1;
      end
   end

   // index captured on the first stalled cycle
   always_ff @(posedge clk) begin
      if (m_req.valid && !busy) begin
         held_sel <= dec_sel;
      end
   end

   assign sel   = busy ? held_sel : dec_sel;
   assign s_sel = sel;

   ////////////////////////////////////////////////////////////////////////////
   // request fan out and response mux
   ////////////////////////////////////////////////////////////////////////////

   // every slave sees addr and data, only one sees valid
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         s_req[i]       = m_req;
         s_req[i].valid = m_req.valid && (sel == slave_sel_t'(i));
      end
   end

   assign m_rsp = s_rsp[sel];

   // a stalled master keeps its request
   a_req_held: assert property (@(posedge clk) disable iff (!reset)
      m_req.valid && !m_rsp.ready |=> m_req.valid && $stable(m_req.addr));

   // slaves may only answer a live request
   a_ready_valid: assert property (@(posedge clk) disable iff (!reset)
      m_rsp.ready |-> m_req.valid);

endmodule

// File: native_ram.sv
`timescale 1ns/1ps

module native_ram import bus_pkg::*; #(
   parameter int addr_w = 14
) (
   input  logic     clk,
   input  logic     reset,
   input  bus_req_t req,
   output bus_rsp_t rsp
);

   localparam int DEPTH = 2 ** (addr_w - 2);

   data_t             mem [DEPTH];
   logic [addr_w-3:0] word_idx;
   logic              ready_q;
   data_t             rdata_q;

   // word index from byte address
   assign word_idx = req.addr[addr_w-1:2];

   // one ready pulse per transfer
   always_ff @(posedge clk) begin
      if (!reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= req.valid && !ready_q;
      end
   end

   // read on first valid cycle, shown with ready
   always_ff @(posedge clk) begin
      if (req.valid && !ready_q) begin
         rdata_q <= mem[word_idx];
      end
   end

   // byte lane writes in the ready cycle
   always_ff @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (req.valid && ready_q && req.wstrb[b]) begin
            mem[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.rdata = rdata_q;

endmodule

// File: uart_baud_timer.sv
`timescale 1ns/1ps

module uart_baud_timer import uart_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  baud_div_t baud_div,
   input  logic      restart,
   output logic      tick
);

   baud_div_t cnt;

   // last cycle of a bit period, zero or one divider ticks every clock
   assign tick = !restart && ((cnt + 1'b1) >= baud_div);

   // restart puts the count back to the start of a period
   always_ff @(posedge clk) begin
      if (!reset) begin
         cnt <= '0;
      end else if (restart || tick) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// File: uart_serial_fsm.sv
`timescale 1ns/1ps

module uart_serial_fsm import uart_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  baud_div_t  baud_div,
   input  logic       tx_start,
   input  uart_byte_t tx_byte,
   output logic       tx_busy,
   output logic       ser_tx,
   input  logic       ser_rx,
   output logic       rx_strobe,
   output uart_byte_t rx_byte
);

   uart_state_t tx_state;
   uart_state_t rx_state;
   uart_byte_t  tx_shift;
   uart_byte_t  rx_shift;
   logic [2:0]  tx_bit;
   logic [2:0]  rx_bit;
   logic        tx_tick;
   logic        rx_tick;
   logic        tx_restart;
   logic        rx_restart;
   logic [1:0]  rx_sync;
   baud_div_t   rx_div;

   ////////////////////////////////////////////////////////////////////////////
   // transmit
   ////////////////////////////////////////////////////////////////////////////

   // align bit timing to the start request
   assign tx_restart = (tx_state == st_idle) && tx_start;
   assign tx_busy    = (tx_state != st_idle);

   uart_baud_timer i_tx_timer (
      .clk      (clk),
      .reset    (reset),
      .baud_div (baud_div),
      .restart  (tx_restart),
      .tick     (tx_tick)
   );

   always_ff @(posedge clk) begin
      if (!reset) begin
         tx_state <= st_idle;
         ser_tx   <= 1'b1;
         tx_bit   <= '0;
      end else begin
         case (tx_state)
            st_idle: begin
               if (tx_start) begin
                  tx_shift <= tx_byte;
                  ser_tx   <= 1'b0;
                  tx_state <= st_start;
               end
            end
            st_start: begin
               if (tx_tick) begin
                  // lsb first
                  ser_tx   <= tx_shift[0];
                  tx_bit   <= '0;
                  tx_state <= st_data;
               end
            end
            st_data: begin
               if (tx_tick) begin
                  tx_shift <= tx_shift >> 1;
                  tx_bit   <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7) begin
                     ser_tx   <= 1'b1;
                     tx_state <= st_stop;
                  end else begin
                     ser_tx <= tx_shift[1];
                  end
               end
            end
            default: begin
               // stop bit, line already high
               if (tx_tick) begin
                  tx_state <= st_idle;
               end
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // receive
   ////////////////////////////////////////////////////////////////////////////

   // two flop synchronizer, idles high
   always_ff @(posedge clk) begin
      if (!reset) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], ser_rx};
      end
   end

   // half period in start state puts later samples mid bit
   assign rx_div     = (rx_state == st_start) ? (baud_div >> 1) : baud_div;
   assign rx_restart = (rx_state == st_idle) && !rx_sync[1];

   uart_baud_timer i_rx_timer (
      .clk      (clk),
      .reset    (reset),
      .baud_div (rx_div),
      .restart  (rx_restart),
      .tick     (rx_tick)
   );

   always_ff @(posedge clk) begin
      if (!reset) begin
         rx_state  <= st_idle;
         rx_strobe <= 1'b0;
         rx_bit    <= '0;
      end else begin
         rx_strobe <= 1'b0;
         case (rx_state)
            st_idle: begin
               // falling edge of start bit
               if (!rx_sync[1]) begin
                  rx_state <= st_start;
               end
            end
            st_start: begin
               if (rx_tick) begin
                  // glitch, not a real start bit
                  rx_state <= rx_sync[1] ? st_idle : st_data;
                  rx_bit   <= '0;
               end
            end
            st_data: begin
               if (rx_tick) begin
                  rx_shift <= {rx_sync[1], rx_shift[7:1]};
                  rx_bit   <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= st_stop;
                  end
               end
            end
            default: begin
               // framing error drops the byte
               if (rx_tick) begin
                  rx_state  <= st_idle;
                  rx_strobe <= rx_sync[1];
               end
            end
         endcase
      end
   end

   // byte held until the next good frame
   always_ff @(posedge clk) begin
      if ((rx_state == st_stop) && rx_tick && rx_sync[1]) begin
         rx_byte <= rx_shift;
      end
   end

endmodule

// File: uart_regs.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module uart_regs import bus_pkg::*, uart_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  bus_req_t   req,
   output bus_rsp_t   rsp,
   input  logic       tx_busy,
   input  logic       rx_strobe,
   input  uart_byte_t rx_byte,
   output baud_div_t  baud_div,
   output logic       tx_start,
   output uart_byte_t tx_byte
);

   logic       div_sel;
   logic       dat_sel;
   logic       dat_we;
   logic       dat_re;
   logic       tx_wait;
   logic       rx_full;
   uart_byte_t rx_buf;
   data_t      div_word;

   // register decode, divider at 4 and data at 8
   assign div_sel = req.valid && req.addr[2];
   assign dat_sel = req.valid && req.addr[3] && !req.addr[2];
   assign dat_we  = dat_sel && (req.wstrb != '0);
   assign dat_re  = dat_sel && (req.wstrb == '0);

   ////////////////////////////////////////////////////////////////////////////
   // divider, byte writable
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      div_word = data_t'(baud_div);
      for (int b = 0; b < 4; b++) begin
         if (div_sel && req.wstrb[b]) begin
            div_word[8*b +: 8] = req.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         baud_div <= baud_div_t'(`UART_DIV_RESET);
      end else begin
         baud_div <= baud_div_t'(div_word);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // data register
   ////////////////////////////////////////////////////////////////////////////

   // write waits for the transmitter
   assign tx_wait  = dat_we && tx_busy;
   assign tx_start = dat_we && !tx_busy;
   assign tx_byte  = req.wdata[7:0];

   // one entry buffer, a new byte overwrites
   always_ff @(posedge clk) begin
      if (!reset) begin
         rx_full <= 1'b0;
      end else begin
         if (dat_re) begin
            rx_full <= 1'b0;
         end
         if (rx_strobe) begin
            rx_full <= 1'b1;
            rx_buf  <= rx_byte;
         end
      end
   end

   // unmapped offsets answer with zero
   assign rsp.ready = req.valid && !tx_wait;
   assign rsp.rdata = div_sel ? data_t'(baud_div)
                    : dat_sel ? (rx_full ? data_t'(rx_buf) : 32'hffff_ffff)
                    : '0;

   // fsm must take the start at once
   a_tx_start: assert property (@(posedge clk) disable iff (!reset)
      tx_start |=> tx_busy);

endmodule

// File: soc_system.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module soc_system import bus_pkg::*, uart_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  bus_req_t   m_req,
   output bus_rsp_t   m_rsp,
   output bus_req_t   sys_s_req,
   input  bus_rsp_t   sys_s_rsp,
   output slave_sel_t s_sel,
   output logic       resetn_int_sys,
   output logic       core_resetn,
   output logic       ser_tx,
   input  logic       ser_rx
);

   bus_req_t   s_req [0:3];
   bus_rsp_t   s_rsp [0:3];
   logic       mem_sel;
   logic       tx_start;
   logic       tx_busy;
   logic       rx_strobe;
   uart_byte_t tx_byte;
   uart_byte_t rx_byte;
   baud_div_t  baud_div;

   ////////////////////////////////////////////////////////////////////////////
   // reset and bus fabric
   ////////////////////////////////////////////////////////////////////////////

   reset_sequencer i_reset_sequencer (
      .clk         (clk),
      .reset       (reset),
      .req         (m_req),
      .rsp_ready   (m_rsp.ready),
      .resetn_int  (resetn_int_sys),
      .core_resetn (core_resetn),
      .mem_sel     (mem_sel)
   );

   native_interconnect i_native_interconnect (
      .clk     (clk),
      .reset   (resetn_int_sys),
      .mem_sel (mem_sel),
      .m_req   (m_req),
      .m_rsp   (m_rsp),
      .s_req   (s_req),
      .s_rsp   (s_rsp),
      .s_sel   (s_sel)
   );

   // slot 1 goes off chip
   assign sys_s_req = s_req[1];
   assign s_rsp[1]  = sys_s_rsp;

   ////////////////////////////////////////////////////////////////////////////
   // memories and uart
   ////////////////////////////////////////////////////////////////////////////

   native_ram #(.addr_w(`SOC_MEM_ADDR_W)) boot_memory (
      .clk   (clk),
      .reset (resetn_int_sys),
      .req   (s_req[0]),
      .rsp   (s_rsp[0])
   );

   native_ram #(.addr_w(`SOC_MEM_ADDR_W)) main_memory (
      .clk   (clk),
      .reset (resetn_int_sys),
      .req   (s_req[3]),
      .rsp   (s_rsp[3])
   );

   uart_regs i_uart_regs (
      .clk       (clk),
      .reset     (resetn_int_sys),
      .req       (s_req[2]),
      .rsp       (s_rsp[2]),
      .tx_busy   (tx_busy),
      .rx_strobe (rx_strobe),
      .rx_byte   (rx_byte),
      .baud_div  (baud_div),
      .tx_start  (tx_start),
      .tx_byte   (tx_byte)
   );

   uart_serial_fsm i_uart_serial_fsm (
      .clk       (clk),
      .reset     (resetn_int_sys),
      .baud_div  (baud_div),
      .tx_start  (tx_start),
      .tx_byte   (tx_byte),
      .tx_busy   (tx_busy),
      .ser_tx    (ser_tx),
      .ser_rx    (ser_rx),
      .rx_strobe (rx_strobe),
      .rx_byte   (rx_byte)
   );

endmodule

// File: tb_soc_system.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module tb_soc_system import bus_pkg::*; ();

   localparam int uart_div     = 4;
   // start, eight data bits and stop
   localparam int frame_cycles = 10 * uart_div;
   localparam int xfer_limit   = 4 * frame_cycles;
   // reset, plain transfers, one held uart write and two received frames
   localparam int watchdog_cycles = 10 + `SOC_POR_CYCLES + 20 * 6 + 3 * frame_cycles + 200;

   logic       clk;
   logic       reset;
   bus_req_t   m_req;
   bus_rsp_t   m_rsp;
   bus_req_t   sys_s_req;
   bus_rsp_t   sys_s_rsp;
   slave_sel_t s_sel;
   logic       resetn_int_sys;
   logic       core_resetn;
   logic       ser_tx;
   logic       ser_rx;

   data_t      last_rdata;
   slave_sel_t last_sel;
   int         last_cycles;
   int         error_count = 0;
   int         check_count = 0;
   int         tests_run   = 0;

   // external slave model state
   data_t      ext_mem [16];
   bus_req_t   ext_seen_req;
   int         ext_delay;
   integer     seed = 39;

   // bytes decoded straight from the transmit line
   logic [7:0] line_byte;
   logic [7:0] line_bytes [$];

   soc_system i_dut (
      .clk            (clk),
      .reset          (reset),
      .m_req          (m_req),
      .m_rsp          (m_rsp),
      .sys_s_req      (sys_s_req),
      .sys_s_rsp      (sys_s_rsp),
      .s_sel          (s_sel),
      .resetn_int_sys (resetn_int_sys),
      .core_resetn    (core_resetn),
      .ser_tx         (ser_tx),
      .ser_rx         (ser_rx)
   );

   // serial loopback
   assign ser_rx = ser_tx;

   always #20 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // external slave on slot 1
   ////////////////////////////////////////////////////////////////////////////

   // request sampled on the rising edge, answer driven on a falling edge
   always begin
      @(posedge clk);
      if (sys_s_req.valid === 1'b1) begin
         ext_delay = $unsigned($random(seed)) % 4;
         repeat (ext_delay) @(posedge clk);
         @(negedge clk);
         ext_seen_req    = sys_s_req;
         sys_s_rsp.rdata = ext_mem[sys_s_req.addr[5:2]];
         sys_s_rsp.ready = 1'b1;
         if (sys_s_req.wstrb != '0) begin
            ext_mem[sys_s_req.addr[5:2]] = merge_bytes(ext_mem[sys_s_req.addr[5:2]],
                                                       sys_s_req.wdata, sys_s_req.wstrb);
         end
         // transfer taken at the rising edge in between
         @(negedge clk);
         sys_s_rsp.ready = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // serial line watcher
   ////////////////////////////////////////////////////////////////////////////

   // start edge, then one sample per bit near its middle on falling edges
   always begin
      @(negedge ser_tx);
      if (resetn_int_sys === 1'b1) begin
         repeat (uart_div / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (uart_div) @(negedge clk);
            line_byte[i] = ser_tx;
         end
         repeat (uart_div) @(negedge clk);
         if (ser_tx !== 1'b1) begin
            error_count++;
            $display("serial line: stop bit of a frame was not high");
         end
         line_bytes.push_back(line_byte);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   // byte lanes with a set strobe take the new data
   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   task automatic compare_values(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error: %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // one master transfer, held until ready
   task automatic bus_transfer(input addr_t addr, input data_t wdata, input strb_t wstrb);
      bit done;
      done = 1'b0;
      @(negedge clk);
      m_req.valid = 1'b1;
      m_req.addr  = addr;
      m_req.wdata = wdata;
      m_req.wstrb = wstrb;
      last_cycles = 0;
      while (!done && last_cycles < xfer_limit) begin
         @(posedge clk);
         last_cycles++;
         if (m_rsp.ready === 1'b1) begin
            done       = 1'b1;
            last_rdata = m_rsp.rdata;
            last_sel   = s_sel;
         end
      end
      if (!done) begin
         error_count++;
         $display("transfer to address %h got no ready within %0d cycles", addr, xfer_limit);
      end
      @(negedge clk);
      m_req.valid = 1'b0;
   endtask

   task automatic bus_write(input addr_t addr, input data_t wdata, input strb_t wstrb);
      bus_transfer(addr, wdata, wstrb);
   endtask

   task automatic bus_read(input addr_t addr);
      bus_transfer(addr, '0, '0);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before) begin
         $display("test %s finished with no errors", name);
      end else begin
         $display("test %s finished with %0d errors", name, error_count - errors_before);
      end
   endtask

   // uart data reads until a byte shows up
   task automatic poll_byte(input string name, input data_t expected);
      int polls;
      polls      = 0;
      last_rdata = 32'hffff_ffff;
      while (last_rdata === 32'hffff_ffff && polls < 3 * frame_cycles) begin
         bus_read(32'h8000_0008);
         polls++;
      end
      if (last_rdata === 32'hffff_ffff) begin
         error_count++;
         $display("%s: no byte came back over the serial loopback", name);
      end else begin
         compare_values(name, expected, last_rdata);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   // called on the falling edge where reset was released
   task automatic reset_release();
      int errors_before;
      int cycles;
      errors_before = error_count;
      cycles        = 0;
      while (resetn_int_sys !== 1'b1 && cycles < 4 * `SOC_POR_CYCLES) begin
         if (core_resetn === 1'b1) begin
            error_count++;
            $display("reset: core reset released before the internal reset");
         end
         @(negedge clk);
         cycles++;
      end
      compare_values("reset", `SOC_POR_CYCLES, cycles);
      compare_values("reset", 1, core_resetn);
      // serial line idles high
      compare_values("reset", 1, ser_tx);
      finish_test("reset", errors_before);
   endtask

   task automatic memory_access();
      int errors_before;
      errors_before = error_count;
      bus_write(32'h0000_0010, 32'h0b00_7001, 4'hf);
      compare_values("memory", 0, last_sel);
      // one cycle to ready
      compare_values("memory", 2, last_cycles);
      bus_write(32'hc000_0010, 32'h3a1a_0010, 4'hf);
      compare_values("memory", 3, last_sel);
      bus_read(32'h0000_0010);
      compare_values("memory", 32'h0b00_7001, last_rdata);
      compare_values("memory", 0, last_sel);
      compare_values("memory", 2, last_cycles);
      bus_read(32'hc000_0010);
      compare_values("memory", 32'h3a1a_0010, last_rdata);
      compare_values("memory", 3, last_sel);
      // partial strobes, bytes 0 and 2 only
      bus_write(32'h0000_0020, 32'h1122_3344, 4'hf);
      bus_write(32'h0000_0020, 32'haabb_ccdd, 4'b0101);
      bus_read(32'h0000_0020);
      compare_values("memory", 32'h11bb_33dd, last_rdata);
      finish_test("memory", errors_before);
   endtask

   task automatic external_slave_access();
      int errors_before;
      errors_before = error_count;
      bus_write(32'h4000_0008, 32'hdead_beef, 4'hf);
      compare_values("external", 1, last_sel);
      compare_values("external", 32'h4000_0008, ext_seen_req.addr);
      compare_values("external", 32'hdead_beef, ext_seen_req.wdata);
      compare_values("external", 4'hf, ext_seen_req.wstrb);
      // done only once the model answers
      compare_values("external", ext_delay + 2, last_cycles);
      bus_write(32'h4000_0008, 32'h0000_1234, 4'b0011);
      compare_values("external", 4'b0011, ext_seen_req.wstrb);
      compare_values("external", ext_delay + 2, last_cycles);
      bus_read(32'h4000_0008);
      compare_values("external", ext_mem[2], last_rdata);
      compare_values("external", 32'hdead_1234, last_rdata);
      compare_values("external", ext_delay + 2, last_cycles);
      // untouched word keeps its fill
      bus_read(32'h4000_0030);
      compare_values("external", ext_mem[12], last_rdata);
      compare_values("external", ext_delay + 2, last_cycles);
      finish_test("external", errors_before);
   endtask

   // relies on main memory word 4 from memory_access
   task automatic boot_remap();
      int errors_before;
      int low_cycles;
      errors_before = error_count;
      low_cycles    = 0;
      compare_values("boot", 1, core_resetn);
      bus_write(`SOC_BOOT_DONE_ADDR, 32'h0, 4'hf);
      // count falling edges with the core held
      while (core_resetn !== 1'b1 && low_cycles < 4 * `SOC_CORE_RST_CYCLES) begin
         low_cycles++;
         @(negedge clk);
      end
      compare_values("boot", `SOC_CORE_RST_CYCLES, low_cycles);
      bus_read(32'h0000_0010);
      compare_values("boot", 32'h3a1a_0010, last_rdata);
      compare_values("boot", 3, last_sel);
      finish_test("boot", errors_before);
   endtask

   task automatic uart_loopback();
      int errors_before;
      errors_before = error_count;
      bus_write(32'h8000_0004, uart_div, 4'hf);
      compare_values("uart", 1, last_cycles);
      bus_read(32'h8000_0004);
      compare_values("uart", uart_div, last_rdata);
      compare_values("uart", 2, last_sel);
      // nothing received yet
      bus_read(32'h8000_0008);
      compare_values("uart", 32'hffff_ffff, last_rdata);
      bus_write(32'h8000_0008, 32'h0000_005a, 4'h1);
      compare_values("uart", 1, last_cycles);
      // held while the first frame goes out
      bus_write(32'h8000_0008, 32'h0000_00c3, 4'h1);
      compare_values("uart", 1, last_cycles >= 8 * uart_div);
      poll_byte("uart", 32'h0000_005a);
      poll_byte("uart", 32'h0000_00c3);
      // frames as they appeared on the line, lsb first
      compare_values("uart", 2, line_bytes.size());
      if (line_bytes.size() == 2) begin
         compare_values("uart", 32'h0000_005a, line_bytes[0]);
         compare_values("uart", 32'h0000_00c3, line_bytes[1]);
      end
      finish_test("uart", errors_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      for (int i = 0; i < 16; i++) begin
         ext_mem[i] = 32'h5a5a_0000 + i;
      end
      clk       = 1'b0;
      reset     = 1'b0;
      m_req     = '0;
      sys_s_rsp = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      reset_release();
      memory_access();
      external_slave_access();
      boot_remap();
      uart_loopback();
      $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+.
bus_pkg.sv
uart_pkg.sv
reset_sequencer.sv
native_interconnect.sv
native_ram.sv
uart_baud_timer.sv
uart_serial_fsm.sv
uart_regs.sv
soc_system.sv
tb_soc_system.sv
